// ==== design/masku_pkg.sv ====
// Mask unit widths, opcode enum, sequencer request and response, lane operand and result structs
package masku_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Lane datapath word
  localparam int unsigned ElenBits = 64;
  // One strobe bit per byte of a lane word
  localparam int unsigned StrbBits = ElenBits / 8;
  // Vector length and element counters
  localparam int unsigned VlBits   = 16;
  // Register file word address of a result
  localparam int unsigned AddrBits = 10;
  // Instruction tag from the sequencer
  localparam int unsigned IdBits   = 3;
  // Scalar result returned to the dispatcher
  localparam int unsigned XlenBits = 64;

  //////////////////////////////
  // Opcodes
  //////////////////////////////

  typedef enum logic [1:0] {
    MASKU_MERGE = 2'd0,
    MASKU_VCPOP = 2'd1
  } masku_op_e;

  //////////////////////////////
  // Structs
  //////////////////////////////

  // Request from the sequencer
  typedef struct packed {
    masku_op_e             op;
    logic [AddrBits-1:0]   vd;
    logic [VlBits-1:0]     vl;
    // High means unmasked
    logic                  vm;
    logic [IdBits-1:0]     id;
  } masku_req_t;

  // Completion back to the sequencer
  typedef struct packed {
    logic                  done;
    logic [IdBits-1:0]     done_id;
  } masku_resp_t;

  // One beat from one lane
  // a is the new result, b the old destination, m the mask
  typedef struct packed {
    logic [ElenBits-1:0]   a;
    logic [ElenBits-1:0]   b;
    logic [ElenBits-1:0]   m;
    logic                  a_valid;
    logic                  b_valid;
    logic                  m_valid;
  } lane_operand_t;

  // One register file write towards one lane
  typedef struct packed {
    logic [AddrBits-1:0]   addr;
    logic [ElenBits-1:0]   wdata;
    logic [StrbBits-1:0]   be;
  } lane_result_t;

endpackage

// ==== design/masku_insn_ctrl.sv ====
// Instruction hold register, issue and commit counters, operand handshake, done and scalar result
`timescale 1ns/1ps

module masku_insn_ctrl #(
  parameter int unsigned NrLanes = 2
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // Sequencer side
  input  masku_pkg::masku_req_t                   req_i,
  input  logic                                    req_valid_i,
  output logic                                    req_ready_o,
  output masku_pkg::masku_resp_t                  resp_o,
  // Lane operands
  input  masku_pkg::lane_operand_t [NrLanes-1:0]  operand_i,
  output logic [NrLanes-1:0]                      operand_ready_o,
  // Towards the ALU
  output masku_pkg::masku_req_t                   insn_o,
  output logic [masku_pkg::VlBits-1:0]            issued_o,
  input  logic [masku_pkg::VlBits-1:0]            popcount_i,
  // Towards the result queue
  output logic                                    push_o,
  output logic [masku_pkg::AddrBits-1:0]          push_addr_o,
  input  logic                                    queue_full_i,
  input  logic                                    queue_retire_i,
  // Scalar result
  output logic [masku_pkg::XlenBits-1:0]          result_scalar_o,
  output logic                                    result_scalar_valid_o
);

  // Elements covered by one beat over all lanes
  localparam int unsigned BeatBits = NrLanes * masku_pkg::ElenBits;
  localparam logic [masku_pkg::VlBits-1:0] BeatElems = BeatBits[masku_pkg::VlBits-1:0];

  // Count down by one beat, floor at zero
  function automatic logic [masku_pkg::VlBits-1:0] beat_sub(
    input logic [masku_pkg::VlBits-1:0] cnt
  );
    if (cnt > BeatElems) begin
      return cnt - BeatElems;
    end
    return '0;
  endfunction

  //////////////////////////////
  // State
  //////////////////////////////

  masku_pkg::masku_req_t         insn_q;
  logic                          insn_valid_q, insn_valid_d;
  // Elements still to be read from the lanes
  logic [masku_pkg::VlBits-1:0]  issue_cnt_q, issue_cnt_d;
  // Elements still to be written back or counted
  logic [masku_pkg::VlBits-1:0]  commit_cnt_q, commit_cnt_d;
  logic [masku_pkg::AddrBits-1:0] beat_q, beat_d;
  // Running VCPOP sum
  logic [masku_pkg::XlenBits-1:0] acc_q, acc_d;
  masku_pkg::masku_resp_t        resp_d;
  logic                          scalar_valid_d;

  logic accept;
  logic operands_valid;
  logic is_vcpop;
  logic take;
  logic finish;

  assign req_ready_o = !insn_valid_q;
  assign accept      = req_valid_i && req_ready_o;
  assign is_vcpop    = insn_q.op == masku_pkg::MASKU_VCPOP;

  // All lanes must present a and b, plus m when masked
  always_comb begin
    operands_valid = 1'b1;
    for (int l = 0; l < NrLanes; l++) begin
      operands_valid &= operand_i[l].a_valid & operand_i[l].b_valid &
                        (insn_q.vm | operand_i[l].m_valid);
    end
  end

  // Beat handshake, merges also need room in the queue
  assign take = insn_valid_q && (issue_cnt_q != '0) && operands_valid &&
                (is_vcpop || !queue_full_i);

  assign operand_ready_o = {NrLanes{take}};
  assign push_o          = take && !is_vcpop;
  assign push_addr_o     = insn_q.vd + beat_q;
  assign insn_o          = insn_q;
  assign issued_o        = insn_q.vl - issue_cnt_q;

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    insn_valid_d   = insn_valid_q;
    issue_cnt_d    = issue_cnt_q;
    commit_cnt_d   = commit_cnt_q;
    beat_d         = beat_q;
    acc_d          = acc_q;
    resp_d         = '0;
    scalar_valid_d = 1'b0;
    finish         = 1'b0;

    if (take) begin
      issue_cnt_d = beat_sub(issue_cnt_q);
      beat_d      = beat_q + 1'b1;
      // VCPOP commits as soon as the beat is counted
      if (is_vcpop) begin
        acc_d = acc_q + {{(masku_pkg::XlenBits - masku_pkg::VlBits){1'b0}}, popcount_i};
        commit_cnt_d = beat_sub(commit_cnt_q);
      end
    end

    // Merge commits when every lane took the head entry
    if (insn_valid_q && !is_vcpop && queue_retire_i) begin
      commit_cnt_d = beat_sub(commit_cnt_q);
    end

    if (insn_valid_q && commit_cnt_d == '0) begin
      finish         = 1'b1;
      insn_valid_d   = 1'b0;
      resp_d.done    = 1'b1;
      resp_d.done_id = insn_q.id;
      scalar_valid_d = is_vcpop;
    end

    if (accept) begin
      insn_valid_d = req_i.vl != '0;
      issue_cnt_d  = req_i.vl;
      commit_cnt_d = req_i.vl;
      beat_d       = '0;
      acc_d        = '0;
      // Empty vector completes right away
      if (req_i.vl == '0) begin
        finish         = 1'b1;
        resp_d.done    = 1'b1;
        resp_d.done_id = req_i.id;
        scalar_valid_d = req_i.op == masku_pkg::MASKU_VCPOP;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      insn_valid_q          <= 1'b0;
      issue_cnt_q           <= '0;
      commit_cnt_q          <= '0;
      beat_q                <= '0;
      acc_q                 <= '0;
      resp_o                <= '0;
      result_scalar_valid_o <= 1'b0;
    end else begin
      insn_valid_q          <= insn_valid_d;
      issue_cnt_q           <= issue_cnt_d;
      commit_cnt_q          <= commit_cnt_d;
      beat_q                <= beat_d;
      acc_q                 <= acc_d;
      resp_o                <= resp_d;
      result_scalar_valid_o <= scalar_valid_d;
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q <= req_i;
    end
    if (finish) begin
      result_scalar_o <= acc_d;
    end
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // Held instruction blocks the sequencer until its done pulse
  a_hold_until_done : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (accept && req_i.vl != '0) |=> (!req_ready_o until resp_o.done));

  // Done is a single-cycle pulse
  a_done_pulse : assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_o.done |=> !resp_o.done);

endmodule

// ==== design/masku_alu.sv ====
// Bit-enable generation from vl and mask, merge datapath and popcount over all lanes
`timescale 1ns/1ps

module masku_alu #(
  parameter int unsigned NrLanes = 2
) (
  input  masku_pkg::masku_req_t                           insn_i,
  input  logic [masku_pkg::VlBits-1:0]                    issued_i,
  input  masku_pkg::lane_operand_t [NrLanes-1:0]          operand_i,
  output logic [NrLanes-1:0][masku_pkg::ElenBits-1:0]     wdata_o,
  output logic [masku_pkg::VlBits-1:0]                    popcount_o
);

  localparam int unsigned BeatBits = NrLanes * masku_pkg::ElenBits;
  localparam logic [masku_pkg::VlBits-1:0] BeatElems = BeatBits[masku_pkg::VlBits-1:0];

  // Elements of the instruction not yet issued
  logic [masku_pkg::VlBits-1:0]                 remaining;
  // Bit enables in plain sequence, lane-major
  logic [BeatBits-1:0]                          vl_en;
  logic [NrLanes-1:0][masku_pkg::ElenBits-1:0]  bit_en;
  // Old destination bits that take part in VCPOP
  logic [BeatBits-1:0]                          cpop_bits;

  assign remaining = insn_i.vl - issued_i;

  //////////////////////////////
  // Tail enable
  //////////////////////////////

  // Full beat when enough elements are left, else a run of low ones
  always_comb begin
    if (remaining >= BeatElems) begin
      vl_en = '1;
    end else begin
      vl_en = ({{(BeatBits - 1){1'b0}}, 1'b1} << remaining) - 1'b1;
    end
  end

  //////////////////////////////
  // Per-lane merge
  //////////////////////////////

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lane
    // Mask only applies when vm is low
    assign bit_en[l] = vl_en[l*masku_pkg::ElenBits +: masku_pkg::ElenBits] &
                       (insn_i.vm ? {masku_pkg::ElenBits{1'b1}} : operand_i[l].m);

    // Enabled bits take the new result, the rest keep b
    assign wdata_o[l] = (operand_i[l].a & bit_en[l]) | (operand_i[l].b & ~bit_en[l]);

    assign cpop_bits[l*masku_pkg::ElenBits +: masku_pkg::ElenBits] = operand_i[l].b & bit_en[l];
  end

  //////////////////////////////
  // Popcount
  //////////////////////////////

  // Adder chain over the whole beat
  always_comb begin
    popcount_o = '0;
    for (int i = 0; i < BeatBits; i++) begin
      popcount_o = popcount_o + {{(masku_pkg::VlBits - 1){1'b0}}, cpop_bits[i]};
    end
  end

endmodule

// ==== design/masku_result_queue.sv ====
// Per-lane result ring with write and read pointers, entry count and request/grant to the lanes
`timescale 1ns/1ps

module masku_result_queue #(
  parameter int unsigned NrLanes          = 2,
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  // Write side from the control
  input  logic                                            push_i,
  input  logic [masku_pkg::AddrBits-1:0]                  push_addr_i,
  input  logic [NrLanes-1:0][masku_pkg::ElenBits-1:0]     wdata_i,
  output logic                                            full_o,
  output logic                                            retire_o,
  // Lane write ports
  output masku_pkg::lane_result_t [NrLanes-1:0]           result_o,
  output logic [NrLanes-1:0]                              result_req_o,
  input  logic [NrLanes-1:0]                              result_gnt_i
);

  localparam int unsigned PtrBits = (ResultQueueDepth > 1) ? $clog2(ResultQueueDepth) : 1;
  localparam int unsigned CntBits = $clog2(ResultQueueDepth + 1);
  localparam int unsigned LastIdx = ResultQueueDepth - 1;

  // Step a pointer around the ring
  function automatic logic [PtrBits-1:0] ptr_inc(input logic [PtrBits-1:0] ptr);
    if (ptr == LastIdx[PtrBits-1:0]) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  //////////////////////////////
  // Storage
  //////////////////////////////

  masku_pkg::lane_result_t [ResultQueueDepth-1:0][NrLanes-1:0] mem_q;
  // One pending bit per entry and lane
  logic [ResultQueueDepth-1:0][NrLanes-1:0] valid_q, valid_d;
  logic [PtrBits-1:0]                       wr_ptr_q, wr_ptr_d;
  logic [PtrBits-1:0]                       rd_ptr_q, rd_ptr_d;
  logic [CntBits-1:0]                       cnt_q, cnt_d;
  // Head lanes still waiting for a grant
  logic [NrLanes-1:0]                       head_left;

  assign full_o       = cnt_q == ResultQueueDepth[CntBits-1:0];
  assign result_o     = mem_q[rd_ptr_q];
  assign result_req_o = valid_q[rd_ptr_q];

  always_comb begin
    valid_d  = valid_q;
    wr_ptr_d = wr_ptr_q;
    rd_ptr_d = rd_ptr_q;
    cnt_d    = cnt_q;

    // Each lane drops its request after its own grant
    head_left          = valid_q[rd_ptr_q] & ~result_gnt_i;
    valid_d[rd_ptr_q]  = head_left;

    // Head leaves once the last lane took it
    retire_o = (cnt_q != '0) && (head_left == '0);
    if (retire_o) begin
      rd_ptr_d = ptr_inc(rd_ptr_q);
      cnt_d    = cnt_d - 1'b1;
    end

    // New entry requests on every lane
    if (push_i) begin
      valid_d[wr_ptr_q] = '1;
      wr_ptr_d          = ptr_inc(wr_ptr_q);
      cnt_d             = cnt_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q  <= valid_d;
      wr_ptr_q <= wr_ptr_d;
      rd_ptr_q <= rd_ptr_d;
      cnt_q    <= cnt_d;
    end
  end

  // Entry payload, same address on every lane
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      for (int l = 0; l < NrLanes; l++) begin
        mem_q[wr_ptr_q][l].addr  <= push_addr_i;
        mem_q[wr_ptr_q][l].wdata <= wdata_i[l];
        // Whole words are written
        mem_q[wr_ptr_q][l].be    <= '1;
      end
    end
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // Control must stall beats while the ring is full
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);

  // Lanes only grant what is requested
  a_gnt_has_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (result_gnt_i & ~result_req_o) == '0);

endmodule

// ==== design/masku_top.sv ====
// Mask unit top level joining instruction control, mask ALU and result queue
`timescale 1ns/1ps

module masku_top #(
  parameter int unsigned NrLanes          = 2,
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // Sequencer
  input  masku_pkg::masku_req_t                   req_i,
  input  logic                                    req_valid_i,
  output logic                                    req_ready_o,
  output masku_pkg::masku_resp_t                  resp_o,
  // Lane operands
  input  masku_pkg::lane_operand_t [NrLanes-1:0]  operand_i,
  output logic [NrLanes-1:0]                      operand_ready_o,
  // Lane results
  output masku_pkg::lane_result_t [NrLanes-1:0]   result_o,
  output logic [NrLanes-1:0]                      result_req_o,
  input  logic [NrLanes-1:0]                      result_gnt_i,
  // Scalar result
  output logic [masku_pkg::XlenBits-1:0]          result_scalar_o,
  output logic                                    result_scalar_valid_o
);

  //////////////////////////////
  // Internal wires
  //////////////////////////////

  masku_pkg::masku_req_t                       insn;
  logic [masku_pkg::VlBits-1:0]                issued;
  logic [masku_pkg::VlBits-1:0]                popcount;
  logic [NrLanes-1:0][masku_pkg::ElenBits-1:0] wdata;
  logic                                        push;
  logic [masku_pkg::AddrBits-1:0]              push_addr;
  logic                                        queue_full;
  logic                                        queue_retire;

  // Instruction hold and beat handshake
  masku_insn_ctrl #(
    .NrLanes (NrLanes)
  ) u_insn_ctrl (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .req_i                 (req_i),
    .req_valid_i           (req_valid_i),
    .req_ready_o           (req_ready_o),
    .resp_o                (resp_o),
    .operand_i             (operand_i),
    .operand_ready_o       (operand_ready_o),
    .insn_o                (insn),
    .issued_o              (issued),
    .popcount_i            (popcount),
    .push_o                (push),
    .push_addr_o           (push_addr),
    .queue_full_i          (queue_full),
    .queue_retire_i        (queue_retire),
    .result_scalar_o       (result_scalar_o),
    .result_scalar_valid_o (result_scalar_valid_o)
  );

  // Merge and popcount on the current beat
  masku_alu #(
    .NrLanes (NrLanes)
  ) u_alu (
    .insn_i     (insn),
    .issued_i   (issued),
    .operand_i  (operand_i),
    .wdata_o    (wdata),
    .popcount_o (popcount)
  );

  // Writeback towards the lanes
  masku_result_queue #(
    .NrLanes          (NrLanes),
    .ResultQueueDepth (ResultQueueDepth)
  ) u_result_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (push),
    .push_addr_i  (push_addr),
    .wdata_i      (wdata),
    .full_o       (queue_full),
    .retire_o     (queue_retire),
    .result_o     (result_o),
    .result_req_o (result_req_o),
    .result_gnt_i (result_gnt_i)
  );

endmodule

// ==== bench/tb_clkgen.sv ====
// Testbench clock source with 20 ns period and active-low reset held for four cycles
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Release one step after the fourth rising edge
  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

// ==== bench/tb_checker.sv ====
// Reference model and result comparison for writes, scalars and done ids, with reporting
`timescale 1ns/1ps

module tb_checker #(
  parameter int unsigned NrLanes = 2
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  masku_pkg::masku_req_t                   req_i,
  input  logic                                    req_valid_i,
  input  logic                                    req_ready_i,
  input  masku_pkg::masku_resp_t                  resp_i,
  input  masku_pkg::lane_operand_t [NrLanes-1:0]  operand_i,
  input  logic [NrLanes-1:0]                      operand_ready_i,
  input  masku_pkg::lane_result_t [NrLanes-1:0]   result_i,
  input  logic [NrLanes-1:0]                      result_req_i,
  input  logic [NrLanes-1:0]                      result_gnt_i,
  input  logic [masku_pkg::XlenBits-1:0]          scalar_i,
  input  logic                                    scalar_valid_i,
  output int                                      err_count_o,
  output int                                      tests_done_o
);

  // Expected writes of one beat with one word per lane
  masku_pkg::lane_result_t [NrLanes-1:0] exp_q [$];
  logic [masku_pkg::IdBits-1:0]          id_q [$];
  masku_pkg::masku_req_t                 cur;
  string  cur_name = "none";
  int     gi [NrLanes];
  int     beat, test_errs, passed, failed, min_gi;
  longint acc;
  bit     active;

  initial begin
    err_count_o  = 0;
    tests_done_o = 0;
    passed = 0;
    failed = 0;
  end

  task automatic set_test_name(input string name);
    cur_name = name;
  endtask

  task automatic print_counts();
    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_done_o, passed, failed, err_count_o);
  endtask

  task automatic fail_note();
    test_errs++;
    err_count_o++;
  endtask

  // Model one beat bit by bit from the vl and mask rules
  task automatic model_beat();
    masku_pkg::lane_result_t [NrLanes-1:0] w;
    bit en;
    for (int l = 0; l < NrLanes; l++) begin
      w[l].addr = cur.vd + beat[masku_pkg::AddrBits-1:0];
      w[l].be   = '1;
      for (int i = 0; i < 64; i++) begin
        en = (beat * NrLanes * 64 + l * 64 + i < int'(cur.vl)) &&
             (cur.vm || operand_i[l].m[i]);
        w[l].wdata[i] = en ? operand_i[l].a[i] : operand_i[l].b[i];
        if (en && operand_i[l].b[i]) acc++;
      end
    end
    if (cur.op == masku_pkg::MASKU_MERGE) exp_q.push_back(w);
    beat++;
  endtask

  always @(posedge clk_i) begin
    if (rst_ni) begin
      // Held instruction keeps the sequencer stalled until its done
      if (active && req_ready_i && !resp_i.done) begin
        $display("%s: request ready high while an instruction is held", cur_name);
        fail_note();
      end

      if (req_valid_i && req_ready_i) begin
        cur = req_i;
        id_q.push_back(req_i.id);
        beat = 0;
        acc = 0;
        test_errs = 0;
        active = (req_i.vl != 0);
      end

      // A lane only requests a merge word that it has not written yet
      for (int l = 0; l < NrLanes; l++) begin
        if (result_req_i[l] && gi[l] >= exp_q.size()) begin
          $display("%s: lane %0d requested a write with none pending", cur_name, l);
          fail_note();
        end
      end

      // All lanes are acknowledged together
      if (operand_ready_i != {NrLanes{operand_ready_i[0]}}) begin
        $display("%s: operand ready differs between lanes", cur_name);
        fail_note();
      end

      // Taken beat needs room in the ring for a merge
      if (operand_ready_i[0]) begin
        min_gi = gi[0];
        for (int l = 1; l < NrLanes; l++) begin
          if (gi[l] < min_gi) min_gi = gi[l];
        end
        if (cur.op == masku_pkg::MASKU_MERGE && exp_q.size() - min_gi >= 2) begin
          $display("%s: operand ready high while the result queue is full", cur_name);
          fail_note();
        end
        model_beat();
      end

      for (int l = 0; l < NrLanes; l++) begin
        if (result_req_i[l] && result_gnt_i[l]) begin
          if (gi[l] >= exp_q.size()) begin
            $display("%s: lane %0d wrote a word that was never expected", cur_name, l);
            fail_note();
          end else begin
            if (result_i[l] !== exp_q[gi[l]][l]) begin
              $display("ERROR %s: lane %0d write expected %h actual %h",
                       cur_name, l, exp_q[gi[l]][l], result_i[l]);
              fail_note();
            end
            gi[l]++;
          end
        end
      end

      if (scalar_valid_i) begin
        if (cur.op != masku_pkg::MASKU_VCPOP) begin
          $display("%s: scalar valid raised for a merge", cur_name);
          fail_note();
        end else if (scalar_i !== acc) begin
          $display("ERROR %s: scalar expected %h actual %h", cur_name, acc, scalar_i);
          fail_note();
        end
      end

      if (resp_i.done) begin
        if (id_q.size() == 0) begin
          $display("%s: done raised with no instruction accepted", cur_name);
          fail_note();
        end else begin
          if (resp_i.done_id !== id_q[0]) begin
            $display("ERROR %s: done id expected %0d actual %0d",
                     cur_name, id_q[0], resp_i.done_id);
            fail_note();
          end
          void'(id_q.pop_front());
        end
        if (cur.op == masku_pkg::MASKU_VCPOP && !scalar_valid_i) begin
          $display("%s: done for VCPOP came without the scalar", cur_name);
          fail_note();
        end
        for (int l = 0; l < NrLanes; l++) begin
          if (gi[l] != exp_q.size()) begin
            $display("%s: lane %0d lost writes before done", cur_name, l);
            fail_note();
          end
          gi[l] = 0;
        end
        exp_q.delete();
        active = 0;
        tests_done_o++;
        if (test_errs == 0) begin
          passed++;
          $display("PASS %s", cur_name);
        end else begin
          failed++;
          $display("FAIL %s with %0d errors", cur_name, test_errs);
        end
      end
    end
  end

endmodule

// ==== bench/tb_masku.sv ====
// Mask unit testbench top with test table, request loop, lane models, DUT and timeout
`timescale 1ns/1ps

module tb_masku;

  localparam int unsigned NrLanes = 2;
  localparam int unsigned NrTests = 9;

  // One row of the test table
  typedef struct packed {
    masku_pkg::masku_op_e              op;
    logic [masku_pkg::VlBits-1:0]      vl;
    logic                              vm;
    logic [masku_pkg::AddrBits-1:0]    vd;
    logic [7:0]                        stall;
  } test_row_t;

  logic clk, rst_n;
  masku_pkg::masku_req_t                   req;
  logic                                    req_valid, req_ready;
  masku_pkg::masku_resp_t                  resp;
  masku_pkg::lane_operand_t [NrLanes-1:0]  operand;
  logic [NrLanes-1:0]                      operand_ready;
  masku_pkg::lane_result_t [NrLanes-1:0]   result;
  logic [NrLanes-1:0]                      result_req, result_gnt, gnt_next;
  logic [masku_pkg::XlenBits-1:0]          scalar;
  logic                                    scalar_valid;
  int                                      err_count, tests_done;

  test_row_t tests [NrTests];
  string     names [NrTests];
  int        seed = 32'h189e_9fce;
  int        stall;
  int        wait_cnt [NrLanes];
  int        cycles;
  int        limit;

  tb_clkgen u_clkgen (.clk_o(clk), .rst_no(rst_n));

  masku_top #(.NrLanes(NrLanes), .ResultQueueDepth(2)) UUT (
    .clk_i(clk), .rst_ni(rst_n),
    .req_i(req), .req_valid_i(req_valid), .req_ready_o(req_ready), .resp_o(resp),
    .operand_i(operand), .operand_ready_o(operand_ready),
    .result_o(result), .result_req_o(result_req), .result_gnt_i(result_gnt),
    .result_scalar_o(scalar), .result_scalar_valid_o(scalar_valid)
  );

  tb_checker #(.NrLanes(NrLanes)) u_checker (
    .clk_i(clk), .rst_ni(rst_n),
    .req_i(req), .req_valid_i(req_valid), .req_ready_i(req_ready), .resp_i(resp),
    .operand_i(operand), .operand_ready_i(operand_ready),
    .result_i(result), .result_req_i(result_req), .result_gnt_i(result_gnt),
    .scalar_i(scalar), .scalar_valid_i(scalar_valid),
    .err_count_o(err_count), .tests_done_o(tests_done)
  );

  // Fresh random words on every lane with all operands valid
  task automatic new_operands();
    for (int l = 0; l < NrLanes; l++) begin
      operand[l].a = {$random(seed), $random(seed)};
      operand[l].b = {$random(seed), $random(seed)};
      operand[l].m = {$random(seed), $random(seed)};
      operand[l].a_valid = 1'b1;
      operand[l].b_valid = 1'b1;
      operand[l].m_valid = 1'b1;
    end
  endtask

  ////////////////////////////////
  // Lane models
  ////////////////////////////////

  // Next beat after each operand handshake
  always @(posedge clk) begin
    if (rst_n && operand_ready[0]) begin
      #1 new_operands();
    end
  end

  // Grant after the stall count with lane 1 one cycle behind lane 0
  always @(posedge clk) begin
    for (int l = 0; l < NrLanes; l++) begin
      gnt_next[l] = 1'b0;
      if (result_gnt[l]) begin
        wait_cnt[l] = 0;
      end else if (result_req[l]) begin
        if (wait_cnt[l] >= stall + l) gnt_next[l] = 1'b1;
        else wait_cnt[l]++;
      end
    end
    #1 result_gnt = gnt_next;
  end

  // Run stops at a budget scaled by beats and stalls
  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("Timeout: no completion within %0d cycles, run stopped", limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    int beats;
    req        = '0;
    req_valid  = 1'b0;
    operand    = '0;
    result_gnt = '0;
    gnt_next   = '0;
    stall      = 0;
    cycles     = 0;
    for (int l = 0; l < NrLanes; l++) wait_cnt[l] = 0;

    // Op, vl, vm, vd, grant stall
    tests[0] = '{masku_pkg::MASKU_MERGE, 16'd256, 1'b1, 10'd10,  8'd0};
    names[0] = "merge_full";
    tests[1] = '{masku_pkg::MASKU_MERGE, 16'd70,  1'b1, 10'd40,  8'd0};
    names[1] = "merge_tail";
    tests[2] = '{masku_pkg::MASKU_MERGE, 16'd200, 1'b0, 10'd100, 8'd1};
    names[2] = "merge_masked";
    tests[3] = '{masku_pkg::MASKU_VCPOP, 16'd300, 1'b1, 10'd0,   8'd0};
    names[3] = "cpop_unmasked";
    tests[4] = '{masku_pkg::MASKU_VCPOP, 16'd256, 1'b0, 10'd0,   8'd0};
    names[4] = "cpop_masked";
    tests[5] = '{masku_pkg::MASKU_VCPOP, 16'd77,  1'b0, 10'd0,   8'd0};
    names[5] = "cpop_tail";
    tests[6] = '{masku_pkg::MASKU_MERGE, 16'd640, 1'b0, 10'd200, 8'd5};
    names[6] = "merge_stall";
    tests[7] = '{masku_pkg::MASKU_VCPOP, 16'd0,   1'b1, 10'd0,   8'd0};
    names[7] = "cpop_empty";
    tests[8] = '{masku_pkg::MASKU_MERGE, 16'd0,   1'b1, 10'd300, 8'd0};
    names[8] = "merge_empty";

    // Reset cycles plus the per-test budget
    limit = 8;
    for (int i = 0; i < NrTests; i++) begin
      beats = (int'(tests[i].vl) + 127) / 128;
      limit += beats * (int'(tests[i].stall) + 4) + 10;
    end

    @(posedge rst_n);
    @(posedge clk);
    #1 new_operands();

    // Each request follows right after the previous done
    for (int i = 0; i < NrTests; i++) begin
      u_checker.set_test_name(names[i]);
      stall     = int'(tests[i].stall);
      req.op    = tests[i].op;
      req.vl    = tests[i].vl;
      req.vm    = tests[i].vm;
      req.vd    = tests[i].vd;
      req.id    = i[masku_pkg::IdBits-1:0];
      req_valid = 1'b1;
      do @(posedge clk); while (!req_ready);
      #1 req_valid = 1'b0;
      do @(posedge clk); while (!resp.done);
      #1;
    end

    repeat (2) @(posedge clk);
    u_checker.print_counts();
    if (err_count == 0 && tests_done == NrTests) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== all.f ====
design/masku_pkg.sv
design/masku_insn_ctrl.sv
design/masku_alu.sv
design/masku_result_queue.sv
design/masku_top.sv
bench/tb_clkgen.sv
bench/tb_checker.sv
bench/tb_masku.sv

// ==== Makefile ====
TOP = tb_masku

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f all.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Simulation finished: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
